//--- verilog/m107_boot_pkg.sv
package m107_boot_pkg;

	// Download index of the game ROM
	localparam logic [7:0] ROM_INDEX = 8'd0;

	localparam int ADDR_W     = 25;
	localparam int DATA_W     = 16;
	localparam int SAMPLE_W   = 16;
	localparam int RESET_HOLD = 16;
	localparam int RST_CNT_W  = $clog2(RESET_HOLD + 1);

	// Menu string, first character in the top byte
	localparam CONF_STR = {
		"AIRASS", ";;",
		"O3,Rotate Controls,Off,On;",
		"O45,Scanlines,Off,25%,50%,75%;",
		"O8,Pause,Off,On;",
		"DIP;",
		"T0,Reset;"
	};
	localparam int CONF_LEN    = $bits(CONF_STR) / 8;
	localparam int CONF_ADDR_W = 10;

	typedef struct packed {
		logic [15:0] dip_sw;
		logic        spare;
		logic        rotate_filter;
		logic        fm_dis;
		logic [3:0]  layer_dis;
		logic        pause;
		logic        blend;
		logic        joyswap;
		logic [1:0]  scanlines;
		logic        rotate;
		logic [1:0]  orientation;
		logic        core_reset;
	} status_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [1:0]        be;
	} rom_wr_t;

	typedef enum logic [1:0] {
		EMPTY,
		LOADING,
		FLUSH,
		RUN
	} boot_state_t;

endpackage

//--- verilog/rom_loader.sv
`timescale 1ns/10ps

module rom_loader (
	input  logic                   CLK_40M,
	input  logic                   rst_n_i,
	input  logic                   ioctl_downl_i,
	input  logic                   ioctl_wr_i,
	input  logic [7:0]             ioctl_index_i,
	input  logic [7:0]             ioctl_data_i,
	input  logic                   mem_ack_i,
	output logic                   mem_req_o,
	output m107_boot_pkg::rom_wr_t mem_wr_o,
	output logic                   ioctl_wait_o,
	output logic                   busy_o
);

	import m107_boot_pkg::*;

	logic [ADDR_W-1:0] byte_addr;
	logic [ADDR_W-1:0] lo_addr;
	logic [7:0]        lo_data;
	logic [7:0]        skid_data;
	logic              skid_valid;
	logic              tail_pend;
	logic              downl_d;
	logic              pending;
	logic              byte_ok;
	logic              odd_byte;
	logic              tail_now;
	logic              issue;
	logic              to_skid;
	rom_wr_t           wr_nxt;

	assign pending  = mem_req_o ^ mem_ack_i;
	assign byte_ok  = ioctl_downl_i & ioctl_wr_i & (ioctl_index_i == ROM_INDEX);
	assign odd_byte = byte_ok & byte_addr[0];
	// Unpaired low byte left over at download end
	assign tail_now = tail_pend | (downl_d & ~ioctl_downl_i & byte_addr[0]);

	always_comb begin
		wr_nxt.addr = lo_addr;
		wr_nxt.data = {ioctl_data_i, lo_data};
		wr_nxt.be   = 2'b11;
		issue       = 1'b0;
		to_skid     = 1'b0;
		if (skid_valid) begin
			wr_nxt.data = {skid_data, lo_data};
			issue       = ~pending;
		end else if (tail_now) begin
			wr_nxt.data = {8'h00, lo_data};
			wr_nxt.be   = 2'b01;
			issue       = ~pending;
		end else if (odd_byte) begin
			issue   = ~pending;
			to_skid = pending;
		end
	end

	always_ff @(posedge CLK_40M or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_req_o  <= 1'b0;
			skid_valid <= 1'b0;
			tail_pend  <= 1'b0;
			downl_d    <= 1'b0;
			byte_addr  <= '0;
		end else begin
			downl_d <= ioctl_downl_i;
			if (issue)
				mem_req_o <= ~mem_req_o;
			if (to_skid)
				skid_valid <= 1'b1;
			else if (issue)
				skid_valid <= 1'b0;
			tail_pend <= tail_now & ~issue;
			// Address restarts from zero for every download
			if (!ioctl_downl_i)
				byte_addr <= '0;
			else if (byte_ok)
				byte_addr <= byte_addr + 1'b1;
		end
	end

	always_ff @(posedge CLK_40M) begin
		if (issue)
			mem_wr_o <= wr_nxt;
		if (byte_ok & ~byte_addr[0]) begin
			lo_data <= ioctl_data_i;
			lo_addr <= byte_addr;
		end
		if (to_skid)
			skid_data <= ioctl_data_i;
	end

	assign ioctl_wait_o = pending | skid_valid | tail_pend;
	assign busy_o       = pending | skid_valid | tail_now;

endmodule

//--- verilog/boot_fsm.sv
`timescale 1ns/10ps

module boot_fsm (
	input  logic                   CLK_40M,
	input  logic                   rst_n_i,
	input  logic                   ioctl_downl_i,
	input  logic                   loader_busy_i,
	input  m107_boot_pkg::status_t status_i,
	input  logic                   button_i,
	output logic                   rst_req_o
);

	import m107_boot_pkg::*;

	boot_state_t state;
	boot_state_t state_nxt;
	logic        downl_d;
	logic        downl_rise;
	logic        downl_fall;

	assign downl_rise = ioctl_downl_i & ~downl_d;
	assign downl_fall = ~ioctl_downl_i & downl_d;

	always_comb begin
		state_nxt = state;
		case (state)
			EMPTY:   if (downl_rise) state_nxt = LOADING;
			LOADING: if (downl_fall) state_nxt = FLUSH;
			// Wait for the trailing write to land
			FLUSH:   if (!loader_busy_i) state_nxt = RUN;
			RUN:     if (downl_rise) state_nxt = LOADING;
			default: state_nxt = EMPTY;
		endcase
	end

	always_ff @(posedge CLK_40M or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state   <= EMPTY;
			downl_d <= 1'b0;
		end else begin
			state   <= state_nxt;
			downl_d <= ioctl_downl_i;
		end
	end

	// Menu reset and front-panel button override a loaded ROM
	assign rst_req_o = (state != RUN) | status_i.core_reset | button_i;

endmodule

//--- verilog/reset_timer.sv
`timescale 1ns/10ps

module reset_timer (
	input  logic CLK_40M,
	input  logic rst_n_i,
	input  logic rst_req_i,
	output logic core_rst_n_o
);

	import m107_boot_pkg::*;

	logic [RST_CNT_W-1:0] cnt;

	always_ff @(posedge CLK_40M or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt          <= RST_CNT_W'(RESET_HOLD);
			core_rst_n_o <= 1'b0;
		end else if (rst_req_i) begin
			cnt          <= RST_CNT_W'(RESET_HOLD);
			core_rst_n_o <= 1'b0;
		end else if (cnt != '0) begin
			cnt          <= cnt - 1'b1;
			// Release together with the last count
			core_rst_n_o <= (cnt == RST_CNT_W'(1));
		end else begin
			core_rst_n_o <= 1'b1;
		end
	end

endmodule

//--- verilog/conf_str_rom.sv
`timescale 1ns/10ps

module conf_str_rom (
	input  logic                                  CLK_40M,
	input  logic [m107_boot_pkg::CONF_ADDR_W-1:0] conf_addr_i,
	output logic [7:0]                            conf_chr_o
);

	import m107_boot_pkg::*;

	always_ff @(posedge CLK_40M) begin
		if (conf_addr_i < CONF_LEN)
			// First character sits in the top byte
			conf_chr_o <= CONF_STR[(CONF_LEN - 1 - int'(conf_addr_i)) * 8 +: 8];
		else
			conf_chr_o <= 8'h00;
	end

endmodule

//--- verilog/audio_dac.sv
`timescale 1ns/10ps

module audio_dac (
	input  logic                                     CLK_40M,
	input  logic                                     rst_n_i,
	input  logic signed [m107_boot_pkg::SAMPLE_W-1:0] sample_i,
	output logic                                     dac_o
);

	import m107_boot_pkg::*;

	logic [SAMPLE_W-1:0] acc;
	logic [SAMPLE_W-1:0] level;
	logic [SAMPLE_W:0]   sum;

	// Offset binary, midscale for a zero sample
	assign level = {~sample_i[SAMPLE_W-1], sample_i[SAMPLE_W-2:0]};
	assign sum   = {1'b0, acc} + {1'b0, level};

	always_ff @(posedge CLK_40M or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc   <= '0;
			dac_o <= 1'b0;
		end else begin
			acc   <= sum[SAMPLE_W-1:0];
			dac_o <= sum[SAMPLE_W];
		end
	end

endmodule

//--- verilog/m107_boot_top.sv
`timescale 1ns/10ps

module m107_boot_top (
	input  logic                                  CLK_40M,
	input  logic                                  rst_n_i,
	input  logic                                  ioctl_downl_i,
	input  logic                                  ioctl_wr_i,
	input  logic [7:0]                            ioctl_index_i,
	input  logic [7:0]                            ioctl_data_i,
	input  m107_boot_pkg::status_t                status_i,
	input  logic                                  button_i,
	input  logic [m107_boot_pkg::CONF_ADDR_W-1:0] conf_addr_i,
	input  logic signed [m107_boot_pkg::SAMPLE_W-1:0] audio_l_i,
	input  logic signed [m107_boot_pkg::SAMPLE_W-1:0] audio_r_i,
	input  logic                                  mem_ack_i,
	output logic                                  mem_req_o,
	output m107_boot_pkg::rom_wr_t                mem_wr_o,
	output logic                                  ioctl_wait_o,
	output logic                                  core_rst_n_o,
	output logic [7:0]                            conf_chr_o,
	output logic                                  dac_l_o,
	output logic                                  dac_r_o
);

	import m107_boot_pkg::*;

	logic loader_busy;
	logic rst_req;

	rom_loader u_loader (
		.CLK_40M       (CLK_40M),
		.rst_n_i       (rst_n_i),
		.ioctl_downl_i (ioctl_downl_i),
		.ioctl_wr_i    (ioctl_wr_i),
		.ioctl_index_i (ioctl_index_i),
		.ioctl_data_i  (ioctl_data_i),
		.mem_ack_i     (mem_ack_i),
		.mem_req_o     (mem_req_o),
		.mem_wr_o      (mem_wr_o),
		.ioctl_wait_o  (ioctl_wait_o),
		.busy_o        (loader_busy)
	);

	boot_fsm u_fsm (
		.CLK_40M       (CLK_40M),
		.rst_n_i       (rst_n_i),
		.ioctl_downl_i (ioctl_downl_i),
		.loader_busy_i (loader_busy),
		.status_i      (status_i),
		.button_i      (button_i),
		.rst_req_o     (rst_req)
	);

	reset_timer u_rst (
		.CLK_40M      (CLK_40M),
		.rst_n_i      (rst_n_i),
		.rst_req_i    (rst_req),
		.core_rst_n_o (core_rst_n_o)
	);

	conf_str_rom u_conf (
		.CLK_40M     (CLK_40M),
		.conf_addr_i (conf_addr_i),
		.conf_chr_o  (conf_chr_o)
	);

	audio_dac u_dac_l (
		.CLK_40M  (CLK_40M),
		.rst_n_i  (rst_n_i),
		.sample_i (audio_l_i),
		.dac_o    (dac_l_o)
	);

	audio_dac u_dac_r (
		.CLK_40M  (CLK_40M),
		.rst_n_i  (rst_n_i),
		.sample_i (audio_r_i),
		.dac_o    (dac_r_o)
	);

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/10ps

module clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o   = 1'b0;
		rst_n_o = 1'b0;
	end

	// 40 ns period
	always #20 clk_o = ~clk_o;

	initial begin
		repeat (10) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

//--- dv/tb_m107_boot.sv
`timescale 1ns/10ps

module tb_m107_boot;

	import m107_boot_pkg::*;

	typedef struct packed {
		logic [7:0]  idx;
		logic [15:0] nbytes;
		logic [7:0]  pat;
		logic [7:0]  nwr;
	} dl_rec_t;

	localparam int N_DL = 4;
	localparam int TMO  = 400;

	logic                       clk;
	logic                       rst_n;
	logic                       downl;
	logic                       wr;
	logic [7:0]                 index;
	logic [7:0]                 data;
	status_t                    status;
	logic                       button;
	logic [CONF_ADDR_W-1:0]     conf_addr;
	logic signed [SAMPLE_W-1:0] audio_l;
	logic signed [SAMPLE_W-1:0] audio_r;
	logic                       mem_ack = 1'b0;
	logic                       mem_req;
	rom_wr_t                    mem_wr;
	logic                       io_wait;
	logic                       core_rst_n;
	logic [7:0]                 conf_chr;
	logic                       dac_l;
	logic                       dac_r;

	integer                     seed = 76;
	dl_rec_t                    dl_tab [N_DL];
	logic signed [SAMPLE_W-1:0] snd_tab [4];
	rom_wr_t                    wr_log [$];
	rom_wr_t                    held;
	logic                       pend_seen;
	int                         delay_cnt;
	string                      conf_text;

	clk_gen u_clk (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	m107_boot_top dut0 (
		.CLK_40M       (clk),
		.rst_n_i       (rst_n),
		.ioctl_downl_i (downl),
		.ioctl_wr_i    (wr),
		.ioctl_index_i (index),
		.ioctl_data_i  (data),
		.status_i      (status),
		.button_i      (button),
		.conf_addr_i   (conf_addr),
		.audio_l_i     (audio_l),
		.audio_r_i     (audio_r),
		.mem_ack_i     (mem_ack),
		.mem_req_o     (mem_req),
		.mem_wr_o      (mem_wr),
		.ioctl_wait_o  (io_wait),
		.core_rst_n_o  (core_rst_n),
		.conf_chr_o    (conf_chr),
		.dac_l_o       (dac_l),
		.dac_r_o       (dac_r)
	);

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input rom_wr_t got, input rom_wr_t exp, input string msg);
		if (got !== exp)
			stop_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string msg);
		if (got !== exp)
			stop_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, msg, got, exp));
	endtask

	task automatic check_chr(input logic [7:0] got, input logic [7:0] exp, input string msg);
		if (got !== exp)
			stop_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp));
	endtask

	function automatic logic [7:0] pat_byte(input logic [7:0] pat, input int j);
		return pat ^ 8'(j * 29) ^ 8'(j >> 4);
	endfunction

	// Expected little-endian word w of a download
	function automatic rom_wr_t exp_write(input dl_rec_t r, input int w);
		rom_wr_t e;
		int      a;
		a      = 2 * w;
		e.addr = ADDR_W'(a);
		if (a + 1 < int'(r.nbytes)) begin
			e.data = {pat_byte(r.pat, a + 1), pat_byte(r.pat, a)};
			e.be   = 2'b11;
		end else begin
			// Odd tail carries only its low byte
			e.data = {8'h00, pat_byte(r.pat, a)};
			e.be   = 2'b01;
		end
		return e;
	endfunction

	// Memory model with random ack latency
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_ack   <= 1'b0;
			pend_seen = 1'b0;
		end else if (mem_req != mem_ack) begin
			if (!pend_seen) begin
				pend_seen = 1'b1;
				held      = mem_wr;
				delay_cnt = {$random(seed)} % 8;
			end else if (mem_wr !== held) begin
				stop_run("memory write port changed while a request was pending");
			end
			if (delay_cnt == 0) begin
				wr_log.push_back(held);
				mem_ack   <= mem_req;
				pend_seen = 1'b0;
			end else begin
				delay_cnt--;
			end
		end
	end

	task automatic download(input dl_rec_t r);
		int j;
		int tmo;
		j   = 0;
		tmo = 0;
		@(posedge clk);
		downl <= 1'b1;
		index <= r.idx;
		while (j < int'(r.nbytes)) begin
			@(posedge clk);
			if (io_wait) begin
				wr <= 1'b0;
				tmo++;
				if (tmo > TMO)
					stop_run("ioctl_wait_o stayed high during download");
			end else begin
				wr   <= 1'b1;
				data <= pat_byte(r.pat, j);
				j++;
				tmo = 0;
			end
		end
		@(posedge clk);
		wr <= 1'b0;
		@(posedge clk);
		downl <= 1'b0;
	endtask

	// Counting starts at the negedge right after the cause cleared
	task automatic measure_release(input string what);
		int n;
		n = 0;
		while (!core_rst_n) begin
			@(negedge clk);
			n++;
			if (n > TMO)
				stop_run($sformatf("core reset never released after %s", what));
		end
		check_bit(n == RESET_HOLD, 1'b1, $sformatf("%s release after %0d cycles", what, n));
	endtask

	task automatic wait_run();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TMO)
				stop_run("boot FSM did not reach RUN after download");
		end while (dut0.u_fsm.state != RUN);
	endtask

	task automatic force_reset(input logic use_button);
		int n;
		n = 0;
		@(posedge clk);
		if (use_button)
			button <= 1'b1;
		else
			status.core_reset <= 1'b1;
		do begin
			@(negedge clk);
			n++;
			if (n > 2)
				stop_run("core reset did not drop within 2 cycles");
		end while (core_rst_n);
		@(posedge clk);
		button            <= 1'b0;
		status.core_reset <= 1'b0;
		@(negedge clk);
		measure_release(use_button ? "button" : "menu reset");
	endtask

	initial begin
		int n;
		int cnt_l;
		int cnt_r;
		int exp_l;
		int exp_r;
		downl     <= 1'b0;
		wr        <= 1'b0;
		index     <= 8'h00;
		data      <= 8'h00;
		status    <= '0;
		button    <= 1'b0;
		conf_addr <= '0;
		audio_l   <= -16'sd32768;
		audio_r   <= -16'sd32768;
		conf_text = {"AIRASS;;O3,Rotate Controls,Off,On;O45,Scanlines,Off,25%,50%,75%;",
			"O8,Pause,Off,On;DIP;T0,Reset;"};
		// idx, byte count, pattern base, expected writes
		dl_tab[0] = '{8'd0, 16'd10, 8'($random(seed)), 8'd5};
		dl_tab[1] = '{8'd0, 16'd7, 8'($random(seed)), 8'd4};
		dl_tab[2] = '{8'd3, 16'd6, 8'($random(seed)), 8'd0};
		dl_tab[3] = '{8'd0, 16'd1, 8'($random(seed)), 8'd1};
		snd_tab[0] = -16'sd32768;
		snd_tab[1] = 16'sd0;
		snd_tab[2] = 16'sd16384;
		snd_tab[3] = 16'sd32767;

		repeat (5) @(negedge clk);
		check_bit(core_rst_n, 1'b0, "core reset in reset");
		check_bit(mem_req, 1'b0, "mem_req in reset");
		check_bit(io_wait, 1'b0, "wait in reset");
		check_bit(dac_l, 1'b0, "left DAC in reset");
		check_bit(dac_r, 1'b0, "right DAC in reset");
		n = 0;
		while (!rst_n) begin
			@(negedge clk);
			n++;
			if (n > 50)
				stop_run("reset never released by clock generator");
		end
		repeat (30) begin
			@(negedge clk);
			check_bit(core_rst_n, 1'b0, "core reset without ROM");
		end

		for (int i = 0; i < N_DL; i++) begin
			wr_log.delete();
			download(dl_tab[i]);
			wait_run();
			measure_release("RUN entry");
			check_bit(wr_log.size() == int'(dl_tab[i].nwr), 1'b1,
				$sformatf("download %0d wrote %0d words", i, wr_log.size()));
			for (int w = 0; w < int'(dl_tab[i].nwr); w++)
				check_word(wr_log[w], exp_write(dl_tab[i], w),
					$sformatf("download %0d word %0d", i, w));
		end

		force_reset(1'b0);
		force_reset(1'b1);

		if (conf_text.len() != CONF_LEN)
			stop_run("configuration string length differs from expected text");
		for (int a = 0; a < CONF_LEN + 3; a++) begin
			@(posedge clk);
			conf_addr <= CONF_ADDR_W'(a);
			@(posedge clk);
			@(negedge clk);
			check_chr(conf_chr, (a < CONF_LEN) ? 8'(conf_text[a]) : 8'h00,
				$sformatf("conf char %0d", a));
		end

		for (int s = 0; s < 4; s++) begin
			@(posedge clk);
			// Opposite ends of the table on the two channels
			audio_l <= snd_tab[s];
			audio_r <= snd_tab[3 - s];
			@(posedge clk);
			cnt_l = 0;
			cnt_r = 0;
			repeat (1024) begin
				@(negedge clk);
				cnt_l += int'(dac_l);
				cnt_r += int'(dac_r);
			end
			exp_l = ((int'(snd_tab[s]) + 32768) * 1024) / 65536;
			exp_r = ((int'(snd_tab[3 - s]) + 32768) * 1024) / 65536;
			check_bit((cnt_l - exp_l <= 1) && (exp_l - cnt_l <= 1), 1'b1,
				$sformatf("left DAC ones %0d for sample %0d", cnt_l, snd_tab[s]));
			check_bit((cnt_r - exp_r <= 1) && (exp_r - cnt_r <= 1), 1'b1,
				$sformatf("right DAC ones %0d for sample %0d", cnt_r, snd_tab[3 - s]));
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- m107_boot.f
verilog/m107_boot_pkg.sv
verilog/rom_loader.sv
verilog/boot_fsm.sv
verilog/reset_timer.sv
verilog/conf_str_rom.sv
verilog/audio_dac.sv
verilog/m107_boot_top.sv
dv/clk_gen.sv
dv/tb_m107_boot.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the m107_boot testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	--top-module tb_m107_boot \
	-f m107_boot.f \
	-o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/sim_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation run failed with status $sim_status"
	exit $sim_status
fi

exit 0
